/* rtl/fma16_settings.svh */
`ifndef FMA16_SETTINGS_SVH
`define FMA16_SETTINGS_SVH

// word address width of the register map (x/y, z/ctrl, status)
`define FMA16_ADR_W 2

// aligned product/addend field; the sticky bit lets anything from 36 up work
`define FMA16_SUM_W 48

// the only NaN the unit ever produces
`define FMA16_CANON_NAN 16'h7E00

`endif

/* rtl/fma16_pkg.sv */
`include "fma16_settings.svh"

package fma16_pkg;

    // binary16 word, seen as raw bits or as fields
    typedef struct packed {
        logic       s;                    // sign
        logic [4:0] e;                    // biased exponent
        logic [9:0] f;                    // fraction
    } fp16_fields_t;

    typedef union packed {
        logic [15:0]  raw;
        fp16_fields_t fld;
    } fp16_t;

    typedef enum logic [1:0] {
        rm_zero = 2'b00,                  // truncate
        rm_even = 2'b01,                  // nearest, ties to even
        rm_down = 2'b10,                  // toward -inf
        rm_up   = 2'b11                   // toward +inf
    } round_mode_e;

    // laid out so bits 21:16 of the control word cast straight in
    typedef struct packed {
        round_mode_e roundmode;
        logic        negz;
        logic        negp;
        logic        add;
        logic        mul;
    } fma16_ctrl_t;

    typedef struct packed {
        logic nv;                         // invalid
        logic of;                         // overflow
        logic uf;                         // underflow
        logic nx;                         // inexact
    } fma16_flags_t;

    typedef struct packed {
        logic zero;
        logic inf;
        logic nan;
        logic snan;
    } fp_class_t;

    ////////////////////////////////////////////////////////////////////////////
    // stage payloads
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic              ps;            // product sign after negp
        logic signed [6:0] pe;            // exponent of product bit 20
        logic [21:0]       pm;            // exact significand product
        logic              zs;            // addend sign after negz
        logic signed [6:0] ze;            // exponent of addend bit 10
        logic [10:0]       zm;
        fp_class_t         cx, cy, cz;
        fma16_ctrl_t       ctrl;
    } prod_stage_t;

    typedef struct packed {
        logic signed [`FMA16_SUM_W+1:0] sum;   // signed aligned sum
        logic              sticky;        // bits lost in alignment
        logic signed [8:0] eb;            // exponent of sum bit 0
        fp16_t             spec_val;      // inf / NaN override
        logic              spec;
        logic              nv;
        round_mode_e       rm;
        logic              ps, zs;        // for the sign of an exact zero
    } sum_stage_t;

endpackage

/* rtl/fma16_op_if.sv */
// one launched operation, register block -> stage 1
interface fma16_op_if
    import fma16_pkg::*;
();
    logic        valid;                   // single-cycle launch strobe
    fp16_t       x;                       // multiplicand
    fp16_t       y;                       // multiplier
    fp16_t       z;                       // addend
    fma16_ctrl_t ctrl;                    // mul/add/negp/negz/rounding

    modport src (
        output valid,
        output x,
        output y,
        output z,
        output ctrl
    );

    modport dst (
        input valid,
        input x,
        input y,
        input z,
        input ctrl
    );
endinterface

/* rtl/fma16_wb_regs.sv */
`include "fma16_settings.svh"

module fma16_wb_regs
    import fma16_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`FMA16_ADR_W-1:0] wb_adr,
    input  logic [31:0]             wb_dat_w,
    output logic [31:0]             wb_dat_r,
    output logic                    wb_ack,
    fma16_op_if.src                 op,
    input  logic                    res_valid,   // completion from stage 3
    input  fp16_t                   res_value,
    input  fma16_flags_t            res_flags
);
    logic         req;                    // new classic cycle, ack not yet given
    logic         launch;                 // write to the control word
    fp16_t        x_q, y_q, z_q;
    fma16_ctrl_t  ctrl_q;
    fp16_t        res_q;                  // latest completion only
    fma16_flags_t flags_q;
    logic [1:0]   inflight;               // ops inside the pipeline
    logic         done_q;
    logic         busy;
    logic [31:0]  rd_data;

    assign req    = wb_cyc & wb_stb & ~wb_ack;
    assign launch = req & wb_we & (wb_adr == `FMA16_ADR_W'd1);
    assign busy   = (inflight != 2'd0);

    // stage 1 samples on the ack edge, so z/ctrl come straight off the bus
    assign op.valid = launch;
    assign op.x     = x_q;
    assign op.y     = y_q;
    assign op.z     = fp16_t'(wb_dat_w[15:0]);
    assign op.ctrl  = fma16_ctrl_t'(wb_dat_w[21:16]);

    always_comb begin
        case (wb_adr)
            `FMA16_ADR_W'd0: rd_data = {y_q.raw, x_q.raw};
            `FMA16_ADR_W'd1: rd_data = {10'd0, ctrl_q, z_q.raw};
            `FMA16_ADR_W'd2: rd_data = {6'd0, done_q, busy, 4'd0, flags_q, res_q.raw};
            default:         rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
            x_q      <= '0;
            y_q      <= '0;
            z_q      <= '0;
            ctrl_q   <= '0;
            res_q    <= '0;
            flags_q  <= '0;
            inflight <= 2'd0;
            done_q   <= 1'b0;
        end else begin
            wb_ack <= req;                        // exactly one cycle per transfer
            if (req && wb_we) begin
                if (wb_adr == `FMA16_ADR_W'd0) begin
                    x_q.raw <= wb_dat_w[15:0];
                    y_q.raw <= wb_dat_w[31:16];
                end
                if (launch) begin
                    z_q.raw <= wb_dat_w[15:0];
                    ctrl_q  <= fma16_ctrl_t'(wb_dat_w[21:16]);
                end
            end
            if (req && !wb_we) wb_dat_r <= rd_data; // valid with ack
            inflight <= inflight + 2'(launch) - 2'(res_valid);
            if (res_valid) begin                    // in-order, newest wins
                res_q   <= res_value;
                flags_q <= res_flags;
            end
            if (launch) done_q <= 1'b0;
            else if (res_valid) done_q <= 1'b1;
        end
    end

    ack_needs_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb));

    // launches are at least two cycles apart, pipeline depth is three
    inflight_max: assert property (@(posedge clk) disable iff (!rst_n)
        inflight <= 2'd2);
endmodule

/* rtl/fma16_unpack_mul.sv */
module fma16_unpack_mul
    import fma16_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    fma16_op_if.dst     op,
    output logic        p_valid,
    output prod_stage_t p_data
);
    fp16_t             y_eff, z_eff;      // after add/mul substitution
    fp_class_t         cx, cy, cz;
    logic [10:0]       sx, sy, sz;        // significands, bit 10 set unless zero
    logic signed [6:0] ex, ey, ez;
    logic              ps;

    function automatic fp_class_t classify(input fp16_t a);
        fp_class_t c;
        c.zero = (a.fld.e == 5'd0)  && (a.fld.f == 10'd0);
        c.inf  = (a.fld.e == 5'h1f) && (a.fld.f == 10'd0);
        c.nan  = (a.fld.e == 5'h1f) && (a.fld.f != 10'd0);
        c.snan = c.nan && !a.fld.f[9];    // quiet bit clear
        return c;
    endfunction

    // left-justify subnormals so every nonzero significand is 1.xxx
    function automatic void unpack(input fp16_t a, output logic [10:0] sig,
                                   output logic signed [6:0] e);
        sig = {(a.fld.e != 5'd0), a.fld.f};
        e   = (a.fld.e == 5'd0) ? -7'sd14 : $signed({2'b00, a.fld.e}) - 7'sd15;
        for (int i = 0; i < 10; i++) begin
            if (sig != 11'd0 && !sig[10]) begin
                sig = sig << 1;
                e   = e - 7'sd1;
            end
        end
        if (sig == 11'd0) e = -7'sd64;    // zero sits below everything
    endfunction

    always_comb begin
        y_eff = op.y;
        if (op.ctrl.add) y_eff.raw = 16'h3C00;              // 1.0
        ps    = op.x.fld.s ^ y_eff.fld.s ^ op.ctrl.negp;
        z_eff = op.z;
        z_eff.fld.s = op.z.fld.s ^ op.ctrl.negz;
        if (op.ctrl.mul) z_eff.raw = {ps, 15'd0};           // zero, product sign
        cx = classify(op.x);
        cy = classify(y_eff);
        cz = classify(z_eff);
        unpack(op.x, sx, ex);
        unpack(y_eff, sy, ey);
        unpack(z_eff, sz, ez);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) p_valid <= 1'b0;
        else        p_valid <= op.valid;
    end

    always_ff @(posedge clk) begin
        if (op.valid) begin
            p_data.ps   <= ps;
            p_data.pe   <= (sx == 11'd0 || sy == 11'd0) ? -7'sd64 : ex + ey;
            p_data.pm   <= sx * sy;                          // exact, 22 bits
            p_data.zs   <= z_eff.fld.s;
            p_data.ze   <= ez;
            p_data.zm   <= sz;
            p_data.cx   <= cx;
            p_data.cy   <= cy;
            p_data.cz   <= cz;
            p_data.ctrl <= op.ctrl;
        end
    end
endmodule

/* rtl/fma16_align_add.sv */
`include "fma16_settings.svh"

module fma16_align_add
    import fma16_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        p_valid,
    input  prod_stage_t p_data,
    output logic        s_valid,
    output sum_stage_t  s_data
);
    localparam int W = `FMA16_SUM_W;

    logic signed [7:0]   pe1, ze8, emax;  // exponents of each operand's top bit
    logic [7:0]          dp, dz;          // right shift of the smaller one
    logic [W-1:0]        pf, zf;
    logic                stp, stz;
    logic                sub;             // effective subtraction
    logic signed [W+1:0] sum;
    logic                any_nan, p_inf, inv_mul, inv_add;
    fp16_t               spec_val;

    // shift right, folding everything that falls off into one bit
    function automatic logic [W:0] shr_sticky(input logic [W-1:0] v, input logic [7:0] d);
        logic [W-1:0] mask;
        mask = ({{(W-1){1'b0}}, 1'b1} << d) - 1'b1;
        return {v >> d, |(v & mask)};
    endfunction

    always_comb begin
        pe1  = $signed(p_data.pe) + 8'sd1;                   // product bit 21
        ze8  = $signed(p_data.ze);
        emax = (pe1 > ze8) ? pe1 : ze8;
        dp   = 8'(emax - pe1);
        dz   = 8'(emax - ze8);
        // larger operand's top bit lands on W-2, bit W-1 is carry room
        {pf, stp} = shr_sticky({1'b0, p_data.pm, {(W-23){1'b0}}}, dp);
        {zf, stz} = shr_sticky({1'b0, p_data.zm, {(W-12){1'b0}}}, dz);
        sub = p_data.ps ^ p_data.zs;
        // subtracting a truncated value needs the lost bits as one lsb
        pf[0] = pf[0] | (sub & stp);
        zf[0] = zf[0] | (sub & stz);
        sum = (p_data.ps ? -$signed({2'b00, pf}) : $signed({2'b00, pf}))
            + (p_data.zs ? -$signed({2'b00, zf}) : $signed({2'b00, zf}));

        //////////////////////////////////////////////////////////////////////////
        // special operands
        //////////////////////////////////////////////////////////////////////////
        any_nan = p_data.cx.nan | p_data.cy.nan | p_data.cz.nan;
        p_inf   = p_data.cx.inf | p_data.cy.inf;
        inv_mul = (p_data.cx.inf & p_data.cy.zero) | (p_data.cy.inf & p_data.cx.zero);
        inv_add = p_inf & ~inv_mul & ~p_data.cx.nan & ~p_data.cy.nan
                & p_data.cz.inf & sub;                      // inf - inf
        if (any_nan || inv_mul || inv_add) spec_val.raw = `FMA16_CANON_NAN;
        else if (p_inf)                    spec_val.raw = {p_data.ps, 5'h1f, 10'd0};
        else                               spec_val.raw = {p_data.zs, 5'h1f, 10'd0};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) s_valid <= 1'b0;
        else        s_valid <= p_valid;
    end

    always_ff @(posedge clk) begin
        if (p_valid) begin
            s_data.sum      <= sum;
            s_data.sticky   <= stp | stz;
            s_data.eb       <= 9'(emax) - 9'sd46 - 9'(W - 48);  // weight of bit 0
            s_data.spec_val <= spec_val;
            s_data.spec     <= any_nan | p_inf | p_data.cz.inf;
            s_data.nv       <= p_data.cx.snan | p_data.cy.snan | p_data.cz.snan
                             | inv_mul | inv_add;
            s_data.rm       <= p_data.ctrl.roundmode;
            s_data.ps       <= p_data.ps;
            s_data.zs       <= p_data.zs;
        end
    end

    // both operands are below 2^(W-1), so the magnitude fits in W+1 bits
    sum_fits: assert property (@(posedge clk) disable iff (!rst_n)
        s_valid |-> (s_data.sum[W+1] == s_data.sum[W]));
endmodule

/* rtl/fma16_round_pack.sv */
`include "fma16_settings.svh"

module fma16_round_pack
    import fma16_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         s_valid,
    input  sum_stage_t   s_data,
    output logic         r_valid,
    output fp16_t        r_value,
    output fma16_flags_t r_flags
);
    localparam int W = `FMA16_SUM_W;

    logic [W+1:0]      neg;
    logic [W:0]        mag;               // |sum|
    logic              rs;                // result sign
    logic [7:0]        lead;              // leading one position
    logic signed [8:0] e_exact, e_res, q, exp_b;
    logic              tiny;              // exact value below 2^-14
    logic [W:0]        kept_w, half;
    logic              guard, rest, nx, inc, ovf, to_inf, zs_rule;
    logic [11:0]       kr;                // rounded significand
    fp16_t             val;
    fma16_flags_t      flg;

    always_comb begin
        neg  = -s_data.sum;
        rs   = s_data.sum[W+1];
        mag  = rs ? neg[W:0] : s_data.sum[W:0];
        lead = 8'd0;
        for (int i = 0; i <= W; i++) begin
            if (mag[i]) lead = 8'(i);
        end
        e_exact = $signed({1'b0, lead}) + s_data.eb;
        tiny    = e_exact < -9'sd14;
        e_res   = tiny ? -9'sd14 : e_exact;                 // subnormal clamp
        q       = e_res - 9'sd10 - s_data.eb;               // position of the ulp

        kept_w = mag >> q[7:0];
        half   = {{W{1'b0}}, 1'b1} << (q[7:0] - 8'd1);
        guard  = |(mag & half);
        rest   = |(mag & (half - 1'b1)) | s_data.sticky;
        nx     = guard | rest;

        case (s_data.rm)
            rm_zero: inc = 1'b0;
            rm_even: inc = guard & (rest | kept_w[0]);
            rm_down: inc = rs & nx;
            default: inc = ~rs & nx;
        endcase
        kr = {1'b0, kept_w[10:0]} + 12'(inc);
        // carry out of rounding bumps the exponent, 1.0*2^-14 leaves subnormal
        if (kr[11])      exp_b = e_res + 9'sd16;
        else if (kr[10]) exp_b = e_res + 9'sd15;
        else             exp_b = 9'sd0;
        ovf = exp_b >= 9'sd31;

        to_inf = (s_data.rm == rm_even) | ((s_data.rm == rm_up) & ~rs)
               | ((s_data.rm == rm_down) & rs);
        // exact zero: like signs keep it, unlike signs give -0 only rounding down
        zs_rule = (s_data.ps == s_data.zs) ? s_data.ps : (s_data.rm == rm_down);

        ////////////////////////////////////////////////////////////////////////////
        // result select
        ////////////////////////////////////////////////////////////////////////////
        if (s_data.spec) begin
            val = s_data.spec_val;
            flg = '{nv: s_data.nv, of: 1'b0, uf: 1'b0, nx: 1'b0};
        end else if (mag == '0) begin
            val.raw = {zs_rule, 15'd0};
            flg     = '0;
        end else if (ovf) begin
            val.raw = to_inf ? {rs, 5'h1f, 10'd0} : {rs, 5'h1e, 10'h3ff};
            flg     = '{nv: 1'b0, of: 1'b1, uf: 1'b0, nx: 1'b1};
        end else begin
            val.raw = {rs, exp_b[4:0], kr[9:0]};             // 2048 has zero fraction
            flg     = '{nv: 1'b0, of: 1'b0, uf: tiny & nx, nx: nx};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) r_valid <= 1'b0;
        else        r_valid <= s_valid;
    end

    always_ff @(posedge clk) begin
        if (s_valid) begin
            r_value <= val;
            r_flags <= flg;
        end
    end

    // NaNs only come from the stage 2 override, never from rounding
    nan_is_canon: assert property (@(posedge clk) disable iff (!rst_n)
        (r_valid && r_value.fld.e == 5'h1f && r_value.fld.f != 10'd0)
            |-> (r_value.raw == `FMA16_CANON_NAN));
endmodule

/* rtl/fma16_wb.sv */
`include "fma16_settings.svh"

module fma16_wb
    import fma16_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`FMA16_ADR_W-1:0] wb_adr,
    input  logic [31:0]             wb_dat_w,
    input  logic [3:0]              wb_sel,      // full-word access only
    output logic [31:0]             wb_dat_r,
    output logic                    wb_ack
);
    fma16_op_if   op ();                  // launch, regs -> stage 1
    logic         p_valid, s_valid, r_valid;
    prod_stage_t  p_data;
    sum_stage_t   s_data;
    fp16_t        r_value;
    fma16_flags_t r_flags;

    ////////////////////////////////////////////////////////////////////////////
    // bus side
    ////////////////////////////////////////////////////////////////////////////
    fma16_wb_regs regs0 (
        .clk, .rst_n,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .op        (op.src),
        .res_valid (r_valid),
        .res_value (r_value),
        .res_flags (r_flags)
    );

    ////////////////////////////////////////////////////////////////////////////
    // three-stage datapath
    ////////////////////////////////////////////////////////////////////////////
    fma16_unpack_mul s1 (.clk, .rst_n, .op(op.dst), .p_valid, .p_data);

    fma16_align_add s2 (.clk, .rst_n, .p_valid, .p_data, .s_valid, .s_data);

    fma16_round_pack s3 (.clk, .rst_n, .s_valid, .s_data, .r_valid, .r_value, .r_flags);
endmodule

/* bench/fma16_ref_model.svh */
// reference for x*y+z, exact in integer units of 2^-48, then one rounding

function automatic logic is_nan(input logic [15:0] a);
    return (a[14:10] == 5'h1f) && (a[9:0] != 10'd0);
endfunction

function automatic logic is_inf(input logic [15:0] a);
    return a[14:0] == 15'h7C00;
endfunction

// value = sig * 2^(scale - 24), subnormals included
function automatic logic [10:0] sig_of(input logic [15:0] a);
    return {a[14:10] != 5'd0, a[9:0]};
endfunction

function automatic int scale_of(input logic [15:0] a);
    return (a[14:10] == 5'd0) ? 0 : int'(a[14:10]) - 1;
endfunction

function automatic int msb_of(input logic [127:0] v);
    int m;
    m = 0;
    for (int i = 0; i < 128; i++) begin
        if (v[i]) m = i;
    end
    return m;
endfunction

// {nv, of, uf, nx, result}; c is {roundmode, negz, negp, add, mul}
function automatic logic [19:0] fma_model(input logic [15:0] x, input logic [15:0] y,
                                          input logic [15:0] z, input logic [5:0] c);
    logic [15:0]  yy, zz;
    logic         ps, zs, rs, nan_in, p_inf, nv, nx, uf, up;
    logic [127:0] pm, zm, mag, kept, rem, half, rnd;
    int           q, l;
    yy     = c[1] ? 16'h3C00 : y;                       // add: y is 1.0
    ps     = x[15] ^ yy[15] ^ c[2];
    zz     = c[0] ? {ps, 15'd0} : {z[15] ^ c[3], z[14:0]};  // mul: zero with product sign
    zs     = zz[15];
    nan_in = is_nan(x) | is_nan(yy) | is_nan(zz);
    p_inf  = is_inf(x) | is_inf(yy);
    nv     = (is_nan(x) & ~x[9]) | (is_nan(yy) & ~yy[9]) | (is_nan(zz) & ~zz[9])
           | (is_inf(x) & (yy[14:0] == 15'd0)) | ((x[14:0] == 15'd0) & is_inf(yy))
           | (~nan_in & p_inf & is_inf(zz) & (ps != zs));   // inf - inf
    if (nan_in | nv) return {nv, 3'b000, 16'h7E00};
    if (p_inf) return {4'b0000, ps, 15'h7C00};
    if (is_inf(zz)) return {4'b0000, zs, 15'h7C00};
    pm = (128'(sig_of(x)) * 128'(sig_of(yy))) << (scale_of(x) + scale_of(yy));
    zm = 128'(sig_of(zz)) << (scale_of(zz) + 24);
    rs = (pm >= zm) ? ps : zs;                          // sign of the larger magnitude
    mag = (ps == zs) ? pm + zm : ((pm >= zm) ? pm - zm : zm - pm);
    if (mag == 128'd0) return {4'b0000, (ps == zs) ? ps : (c[5:4] == 2'b10), 15'd0};
    // ulp 2^(e-10), never finer than the subnormal step 2^-24
    q    = (msb_of(mag) > 34) ? msb_of(mag) - 10 : 24;
    kept = mag >> q;
    rem  = mag - (kept << q);
    half = 128'd1 << (q - 1);
    nx   = rem != 128'd0;
    case (c[5:4])
        2'b00:   up = 1'b0;
        2'b01:   up = (rem > half) | ((rem == half) & kept[0]);
        2'b10:   up = rs & nx;
        default: up = ~rs & nx;
    endcase
    rnd = (kept + 128'(up)) << q;
    uf  = (mag < (128'd1 << 34)) & nx;                  // tiny before rounding
    if (rnd >= (128'd1 << 64)) begin                    // reached 2^16
        if (c[5:4] == 2'b01 || c[5:4] == {1'b1, ~rs}) return {4'b0101, rs, 15'h7C00};
        return {4'b0101, rs, 15'h7BFF};                 // largest finite
    end
    if (rnd < (128'd1 << 34)) return {2'b00, uf, nx, rs, 5'd0, rnd[33:24]};
    l = msb_of(rnd);
    return {2'b00, uf, nx, rs, 5'(l - 33), 10'(rnd >> (l - 10))};
endfunction

/* bench/tb_fma16.sv */
`include "fma16_settings.svh"

module tb_fma16;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_RAND = 2000;                 // plain fmadd
    localparam int N_CTRL = 400;                  // random mul/add/negp/negz
    localparam int N_EDGE = 300;                  // subnormal range
    localparam int N_OPS  = N_RAND + N_CTRL + N_EDGE + 600;  // specials, directed

    logic                    clk, rst_n;
    logic                    wb_cyc, wb_stb, wb_we, wb_ack;
    logic [`FMA16_ADR_W-1:0] wb_adr;
    logic [31:0]             wb_dat_w, wb_dat_r;
    logic [3:0]              wb_sel;
    logic [31:0]             rng;                 // xorshift state
    logic [15:0]             specials [8];

    `include "fma16_ref_model.svh"

    fma16_wb dut0 (.clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
                   .wb_dat_w, .wb_sel, .wb_dat_r, .wb_ack);

    always #50 clk = ~clk;

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got === want) else begin
            $display("mismatch at %0t ns: %s expected %h got %h", $time, name, want, got);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // a quarter of the draws land on exponent 0, 30 or 31
    function automatic logic [15:0] rand_fp16();
        logic [31:0] r;
        r = next_rand();
        if (r[31:30] == 2'b00) r[14:10] = (r[29:28] == 2'b00) ? 5'd0 : (r[29] ? 5'd31 : 5'd30);
        return r[15:0];
    endfunction

    function automatic logic [15:0] rand_exp(input logic [4:0] base);
        logic [31:0] r;
        r = next_rand();
        r[14:10] = base + {2'b00, r[12:10]};      // base .. base+7
        return r[15:0];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // bus transfers start 1 ns after a rising edge
    ////////////////////////////////////////////////////////////////////////////
    task automatic bus_xfer(input logic we, input logic [`FMA16_ADR_W-1:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(posedge clk);
            #1;
        end while (!wb_ack);
        rdata = wb_dat_r;                         // valid with ack
        @(posedge clk);                           // strobe held through the ack edge
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        assert (!wb_ack) else begin
            $display("ack stayed high for more than one cycle");
            abort_run();
        end
    endtask

    // poll status until done and nothing left in flight
    task automatic wait_idle(output logic [31:0] st);
        int polls;
        polls = 0;
        do begin
            bus_xfer(1'b0, `FMA16_ADR_W'd2, 32'd0, st);
            polls++;
            assert (polls < 20) else begin
                $display("operation never completed after launch");
                abort_run();
            end
        end while (!(st[25] && !st[24]));
    endtask

    task automatic run_op(input logic [15:0] x, input logic [15:0] y,
                          input logic [15:0] z, input logic [5:0] c);
        logic [31:0] st;
        bus_xfer(1'b1, `FMA16_ADR_W'd0, {y, x}, st);
        bus_xfer(1'b1, `FMA16_ADR_W'd1, {10'd0, c, z}, st);     // launch
        wait_idle(st);
        check_eq("result/flags", 32'(st[19:0]), 32'(fma_model(x, y, z, c)));
    endtask

    initial begin
        logic [31:0] xy, zc, rd;
        clk      = 1'b0;
        rst_n    = 1'b0;
        {wb_cyc, wb_stb, wb_we} = 3'b000;
        wb_adr   = '0;
        wb_dat_w = 32'd0;
        wb_sel   = 4'hF;
        rng      = 32'd77949;
        specials = '{16'h7E00, 16'h7D00, 16'h7C00, 16'hFC00,
                     16'h0000, 16'h8000, 16'h3C00, 16'hC000};
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // read-back, busy right after launch, done three edges later
        xy = next_rand();
        zc = next_rand() & 32'h003F_FFFF;
        bus_xfer(1'b1, `FMA16_ADR_W'd0, xy, rd);
        bus_xfer(1'b1, `FMA16_ADR_W'd1, zc, rd);
        bus_xfer(1'b0, `FMA16_ADR_W'd2, 32'd0, rd);
        check_eq("done/busy", 32'(rd[25:24]), 32'd1);
        wait_idle(rd);
        check_eq("result/flags", 32'(rd[19:0]),
                 32'(fma_model(xy[15:0], xy[31:16], zc[15:0], zc[21:16])));
        bus_xfer(1'b0, `FMA16_ADR_W'd0, 32'd0, rd);
        check_eq("x/y word", rd, xy);
        bus_xfer(1'b0, `FMA16_ADR_W'd1, 32'd0, rd);
        check_eq("z/ctrl word", rd, zc);

        repeat (N_RAND) begin
            xy = next_rand();
            run_op(rand_fp16(), rand_fp16(), rand_fp16(), {xy[1:0], 4'b0000});
        end
        repeat (N_CTRL) begin
            xy = next_rand();
            run_op(rand_fp16(), rand_fp16(), rand_fp16(), xy[5:0]);
        end
        for (int i = 0; i < 512; i++) begin      // every special triple
            xy = next_rand();
            run_op(specials[i[8:6]], specials[i[5:3]], specials[i[2:0]], {xy[3:0], 2'b00});
        end

        ////////////////////////////////////////////////////////////////////////
        // range edges
        ////////////////////////////////////////////////////////////////////////
        for (int m = 0; m < 16; m++) begin       // 65504 + 16 or 32, both signs
            run_op(16'h7BFF, {m[2], 15'h3C00}, {m[2], m[3] ? 15'h5000 : 15'h4C00},
                   {2'(m), 4'b0000});
        end
        repeat (N_EDGE) begin
            xy = next_rand();
            run_op(rand_exp(5'd0), rand_exp(5'd13), rand_exp(5'd0), {xy[3:0], 2'b00});
        end
        bus_xfer(1'b1, `FMA16_ADR_W'd0, 32'h4500_4200, rd);     // 3.0 * 5.0
        bus_xfer(1'b1, `FMA16_ADR_W'd1, 32'h0010_3C00, rd);     // + 1.0 to nearest
        bus_xfer(1'b1, `FMA16_ADR_W'd1, 32'h0030_C400, rd);     // - 4.0 upward overwrites it
        wait_idle(rd);
        check_eq("result/flags", 32'(rd[19:0]), 32'(fma_model(16'h4200, 16'h4500,
                 16'hC400, 6'b110000)));

        $display("All tests passed");
        $finish;
    end

    // budget of 200 cycles per operation
    initial begin
        #(N_OPS * 200 * 100 + 10_000);
        $display("watchdog expired before all operations finished");
        abort_run();
    end
endmodule

/* fma16_wb.f */
+incdir+rtl
+incdir+bench
rtl/fma16_pkg.sv
rtl/fma16_op_if.sv
rtl/fma16_wb_regs.sv
rtl/fma16_unpack_mul.sv
rtl/fma16_align_add.sv
rtl/fma16_round_pack.sv
rtl/fma16_wb.sv
bench/tb_fma16.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fma16 testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_fma16 -f fma16_wb.f -o sim_fma16
./obj_dir/sim_fma16 | tee sim.log
if grep -q "All tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
